//--- Makefile
# Verilator build and run of the buffer manager testbench.
TOP := buf_mgr_tb
SRCS := tb.f $(wildcard include/*.svh design/*.sv dv/*.sv)

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	-./obj_dir/V$(TOP) > sim.log 2>&1
	cat sim.log
	@! grep -q "TEST RESULT: FAIL" sim.log
	@grep -q "TEST RESULT: PASS" sim.log

lint:
	verilator --lint-only --timing -Wall -f tb.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

//--- design/buf_mgr_top.sv
/*
 * Top level of the packet buffer with its free-list allocator.
 * Clients malloc words through ma_write/ma_din and learn the address on
 * ma_adr, overwrite through wr_req, read through two read ports and
 * return addresses through the dequeue ports.
 * Wait for ready and respect ma_bp before issuing mallocs.
 */

`timescale 1ns/1ps

`include "buf_cfg.svh"

module buf_mgr_top import buf_pkg::*; (
  input  logic                              clk,
  input  logic                              arst_n,
  output logic                              ready,

  // malloc ports.
  input  logic [`BUF_NUMMAPT-1:0]           ma_write,
  input  buf_data_t [`BUF_NUMMAPT-1:0]      ma_din,
  output buf_addr_t [`BUF_NUMMAPT-1:0]      ma_adr,
  output logic                              ma_bp,
  input  logic [7:0]                        bp_thr,

  // client write port.
  input  buf_wr_req_t                       wr_req,

  // read ports.
  input  logic [`BUF_NUMRDPT-1:0]           read,
  input  buf_addr_t [`BUF_NUMRDPT-1:0]      rd_adr,
  output buf_rd_rsp_t [`BUF_NUMRDPT-1:0]    rd_rsp,

  // dequeue ports.
  input  logic [`BUF_NUMDQPT-1:0]           dq_vld,
  input  buf_addr_t [`BUF_NUMDQPT-1:0]      dq_adr
);

  buf_wr_req_t [`BUF_NUMMAPT-1:0] ma_req;

  free_list free_list_i (
    .clk      (clk),
    .arst_n   (arst_n),
    .ma_write (ma_write),
    .dq_vld   (dq_vld),
    .dq_adr   (dq_adr),
    .bp_thr   (bp_thr),
    .ma_adr   (ma_adr),
    .ma_bp    (ma_bp),
    .ready    (ready)
  );

  // a malloc writes its data at the address the allocator offers
  // in the same cycle.
  for (genvar p = 0; p < `BUF_NUMMAPT; p++) begin : g_ma_req
    assign ma_req[p].vld  = ma_write[p];
    assign ma_req[p].adr  = ma_adr[p];
    assign ma_req[p].data = ma_din[p];
  end

  data_store data_store_i (
    .clk    (clk),
    .arst_n (arst_n),
    .wr_req (wr_req),
    .ma_req (ma_req),
    .read   (read),
    .rd_adr (rd_adr),
    .rd_rsp (rd_rsp)
  );

endmodule

//--- design/buf_pkg.sv
/*
 * Types shared by the buffer manager blocks and its testbench.
 * Modules take them with a wildcard import in the module header.
 * Sizes come from the buffer configuration header.
 */

`include "buf_cfg.svh"

package buf_pkg;

  // one buffer address.
  typedef logic [`BUF_BITADDR-1:0] buf_addr_t;

  // one buffer word.
  typedef logic [`BUF_WIDTH-1:0] buf_data_t;

  // free count, which must also hold the value BUF_NUMADDR.
  typedef logic [$clog2(`BUF_NUMADDR+1)-1:0] buf_cnt_t;

  // a write into the word store.
  // the client write port and every malloc port use this form.
  typedef struct packed {
    logic      vld;
    buf_addr_t adr;
    buf_data_t data;
  } buf_wr_req_t;

  // a read response, one cycle after the read strobe.
  typedef struct packed {
    logic      vld;
    buf_data_t data;
  } buf_rd_rsp_t;

endpackage

//--- design/data_store.sv
/*
 * Word store of the packet buffer.
 * Malloc writes and the client write land at the clock edge, the client
 * write last so that it wins an address collision.
 * Each read port returns its word and a valid flag one cycle later.
 */

`timescale 1ns/1ps

`include "buf_cfg.svh"

module data_store import buf_pkg::*; (
  input  logic                              clk,
  input  logic                              arst_n,
  input  buf_wr_req_t                       wr_req,
  input  buf_wr_req_t [`BUF_NUMMAPT-1:0]    ma_req,
  input  logic [`BUF_NUMRDPT-1:0]           read,
  input  buf_addr_t [`BUF_NUMRDPT-1:0]      rd_adr,
  output buf_rd_rsp_t [`BUF_NUMRDPT-1:0]    rd_rsp
);

  buf_data_t mem [`BUF_NUMADDR];

  logic [`BUF_NUMRDPT-1:0] rd_vld_q;
  buf_data_t               rd_data_q [`BUF_NUMRDPT];

  // later assignments override earlier ones on the same address,
  // which gives malloc port 0, then port 1, then the client write.
  always_ff @(posedge clk) begin
    for (int p = 0; p < `BUF_NUMMAPT; p++) begin
      if (ma_req[p].vld) begin
        mem[ma_req[p].adr] <= ma_req[p].data;
      end
    end
    if (wr_req.vld) begin
      mem[wr_req.adr] <= wr_req.data;
    end
  end

  // a read in the same cycle as a write to its address sees the old word.
  always_ff @(posedge clk) begin
    for (int p = 0; p < `BUF_NUMRDPT; p++) begin
      if (read[p]) begin
        rd_data_q[p] <= mem[rd_adr[p]];
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_vld_q <= '0;
    end else begin
      rd_vld_q <= read;
    end
  end

  always_comb begin
    for (int p = 0; p < `BUF_NUMRDPT; p++) begin
      rd_rsp[p].vld  = rd_vld_q[p];
      rd_rsp[p].data = rd_data_q[p];
    end
  end

  // the allocator hands each malloc port a distinct queue entry, so two
  // malloc writes to one address point at a corrupted free list.
  for (genvar i = 0; i < `BUF_NUMMAPT; i++) begin : g_ma_i
    for (genvar j = i + 1; j < `BUF_NUMMAPT; j++) begin : g_ma_j
      a_ma_adr_unique: assert property (
        @(posedge clk) disable iff (!arst_n)
        (ma_req[i].vld && ma_req[j].vld) |-> (ma_req[i].adr != ma_req[j].adr)
      ) else $error("malloc ports %0d and %0d share an address", i, j);
    end
  end

endmodule

//--- design/free_list.sv
/*
 * Free-list address allocator for the packet buffer.
 * A circular queue of free addresses is filled by a sweep after reset,
 * then malloc ports pop from the head and dequeue ports push at the tail.
 * A registered free count drives the back-pressure level ma_bp.
 */

`timescale 1ns/1ps

`include "buf_cfg.svh"

module free_list import buf_pkg::*; (
  input  logic                              clk,
  input  logic                              arst_n,
  input  logic [`BUF_NUMMAPT-1:0]           ma_write,
  input  logic [`BUF_NUMDQPT-1:0]           dq_vld,
  input  buf_addr_t [`BUF_NUMDQPT-1:0]      dq_adr,
  input  logic [7:0]                        bp_thr,
  output buf_addr_t [`BUF_NUMMAPT-1:0]      ma_adr,
  output logic                              ma_bp,
  output logic                              ready
);

  localparam buf_addr_t LAST_ADR = buf_addr_t'(`BUF_NUMADDR - 1);
  localparam buf_cnt_t  FULL_CNT = buf_cnt_t'(`BUF_NUMADDR);

  // queue storage, one free address per slot.
  buf_addr_t fl_q [`BUF_NUMADDR];

  buf_addr_t head;
  buf_addr_t tail;
  buf_cnt_t  count;
  buf_addr_t init_adr;

  // each port's slot offset is the number of strobes on lower ports.
  buf_addr_t pop_off  [`BUF_NUMMAPT];
  buf_addr_t push_off [`BUF_NUMDQPT];
  buf_cnt_t  npop;
  buf_cnt_t  npush;

  always_comb begin
    pop_off[0] = '0;
    for (int p = 1; p < `BUF_NUMMAPT; p++) begin
      pop_off[p] = pop_off[p-1] + buf_addr_t'(ma_write[p-1]);
    end
    npop = buf_cnt_t'(pop_off[`BUF_NUMMAPT-1]) + buf_cnt_t'(ma_write[`BUF_NUMMAPT-1]);
  end

  always_comb begin
    push_off[0] = '0;
    for (int p = 1; p < `BUF_NUMDQPT; p++) begin
      push_off[p] = push_off[p-1] + buf_addr_t'(dq_vld[p-1]);
    end
    npush = buf_cnt_t'(push_off[`BUF_NUMDQPT-1]) + buf_cnt_t'(dq_vld[`BUF_NUMDQPT-1]);
  end

  // the address for port p is the entry p-offset behind the head, so a
  // higher port sees the next entry only when a lower port pops too.
  always_comb begin
    for (int p = 0; p < `BUF_NUMMAPT; p++) begin
      ma_adr[p] = fl_q[head + pop_off[p]];
    end
  end

  // during the sweep slot i receives address i; afterwards the dequeue
  // ports write in port order starting at the tail.
  always_ff @(posedge clk) begin
    if (!ready) begin
      fl_q[init_adr] <= init_adr;
    end else begin
      for (int p = 0; p < `BUF_NUMDQPT; p++) begin
        if (dq_vld[p]) begin
          fl_q[tail + push_off[p]] <= dq_adr[p];
        end
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ready    <= 1'b0;
      init_adr <= '0;
      head     <= '0;
      tail     <= '0;
      count    <= '0;
      ma_bp    <= 1'b1;
    end else begin
      // back-pressure follows the registered count by one cycle.
      ma_bp <= !ready || ({1'b0, count} <= bp_thr);
      if (!ready) begin
        // the sweep leaves the tail at zero once it has wrapped.
        init_adr <= init_adr + 1'b1;
        count    <= count + 1'b1;
        if (init_adr == LAST_ADR) begin
          ready <= 1'b1;
        end
      end else begin
        head  <= head + buf_addr_t'(npop);
        tail  <= tail + buf_addr_t'(npush);
        count <= count + npush - npop;
      end
    end
  end

  // a full list means every address is free, so a dequeue would
  // return an address that was never handed out.
  a_no_push_full: assert property (
    @(posedge clk) disable iff (!arst_n)
    (ready && count == FULL_CNT) |-> !(|dq_vld)
  ) else $error("dequeue while the free list is full");

  // clients must honour back-pressure, since nothing here stalls them.
  a_no_pop_bp: assert property (
    @(posedge clk) disable iff (!arst_n)
    (|ma_write) |-> !ma_bp
  ) else $error("malloc while ma_bp is high");

  a_no_pop_init: assert property (
    @(posedge clk) disable iff (!arst_n)
    (|ma_write) |-> ready
  ) else $error("malloc before the free list is ready");

endmodule

//--- dv/buf_mgr_tb.sv
/*
 * Testbench for the packet buffer manager.
 * A table of client operations is applied one row per clock cycle, and a
 * reference model of the free queue, the word store and the free count
 * predicts every response. The run stops at the first mismatch.
 */

`timescale 1ns/1ps

`include "buf_cfg.svh"

module buf_mgr_tb import buf_pkg::*; ();

  localparam logic [31:0] SEED = 32'h76eeedf1;

  // one cycle of client activity.
  typedef struct packed {
    logic [`BUF_NUMMAPT-1:0]      ma_mask;
    logic                         wr_vld;
    buf_addr_t                    wr_adr;
    logic [`BUF_NUMRDPT-1:0]      rd_mask;
    buf_addr_t [`BUF_NUMRDPT-1:0] rd_adr;
    logic [`BUF_NUMDQPT-1:0]      dq_mask;
    buf_addr_t [`BUF_NUMDQPT-1:0] dq_adr;
    logic [7:0]                   thr;
  } row_t;

  logic                           clk;
  logic                           arst_n;
  logic                           ready;
  logic [`BUF_NUMMAPT-1:0]        ma_write;
  buf_data_t [`BUF_NUMMAPT-1:0]   ma_din;
  buf_addr_t [`BUF_NUMMAPT-1:0]   ma_adr;
  logic                           ma_bp;
  logic [7:0]                     bp_thr;
  buf_wr_req_t                    wr_req;
  logic [`BUF_NUMRDPT-1:0]        read;
  buf_addr_t [`BUF_NUMRDPT-1:0]   rd_adr;
  buf_rd_rsp_t [`BUF_NUMRDPT-1:0] rd_rsp;
  logic [`BUF_NUMDQPT-1:0]        dq_vld;
  buf_addr_t [`BUF_NUMDQPT-1:0]   dq_adr;

  row_t                    rows [$];
  row_t                    idle_row;
  buf_addr_t               free_q [$];
  buf_data_t               mem_model [`BUF_NUMADDR];
  logic [`BUF_NUMADDR-1:0] mem_known;
  int                      m_count;
  logic                    m_ready;
  logic                    m_bp;
  logic [`BUF_NUMRDPT-1:0] exp_vld;
  logic [`BUF_NUMRDPT-1:0] exp_known;
  buf_data_t               exp_data [`BUF_NUMRDPT];
  logic [31:0]             rng;
  int                      errors;
  int                      cycles;
  int                      cycle_limit;

  buf_mgr_top buf_mgr_top_i (
    .clk      (clk),
    .arst_n   (arst_n),
    .ready    (ready),
    .ma_write (ma_write),
    .ma_din   (ma_din),
    .ma_adr   (ma_adr),
    .ma_bp    (ma_bp),
    .bp_thr   (bp_thr),
    .wr_req   (wr_req),
    .read     (read),
    .rd_adr   (rd_adr),
    .rd_rsp   (rd_rsp),
    .dq_vld   (dq_vld),
    .dq_adr   (dq_adr)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic bit is_free(input buf_addr_t a);
    foreach (free_q[i]) begin
      if (free_q[i] == a) begin
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  task automatic report_error(input string msg);
    errors++;
    $display("%s", msg);
    $display("TEST RESULT: FAIL");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic add_row(input logic [`BUF_NUMMAPT-1:0] ma, input int wr_vld, input int wr_adr,
                         input logic [`BUF_NUMRDPT-1:0] rd, input int ra0, input int ra1,
                         input logic [`BUF_NUMDQPT-1:0] dq, input int da0, input int da1,
                         input int thr);
    row_t r;
    r.ma_mask   = ma;
    r.wr_vld    = (wr_vld != 0);
    r.wr_adr    = buf_addr_t'(wr_adr);
    r.rd_mask   = rd;
    r.rd_adr[0] = buf_addr_t'(ra0);
    r.rd_adr[1] = buf_addr_t'(ra1);
    r.dq_mask   = dq;
    r.dq_adr[0] = buf_addr_t'(da0);
    r.dq_adr[1] = buf_addr_t'(da1);
    r.thr       = 8'(thr);
    rows.push_back(r);
  endtask

  // addresses are handed out as 0, 1, 2 and so on, which fixes the
  // read and dequeue addresses below.
  task automatic build_table();
    int fa;
    add_row(2'b00, 0, 0, 2'b00, 0, 0, 2'b00, 0, 0, 40);
    add_row(2'b11, 0, 0, 2'b00, 0, 0, 2'b00, 0, 0, 40);
    add_row(2'b01, 0, 0, 2'b00, 0, 0, 2'b00, 0, 0, 40);
    add_row(2'b10, 0, 0, 2'b00, 0, 0, 2'b00, 0, 0, 40);
    add_row(2'b11, 0, 0, 2'b11, 0, 1, 2'b00, 0, 0, 40);
    // the client write and read port 0 meet at address 4.
    add_row(2'b11, 1, 4, 2'b11, 4, 2, 2'b00, 0, 0, 40);
    // port 1 allocates address 9 here and the client write overrides it.
    add_row(2'b11, 1, 9, 2'b11, 4, 3, 2'b00, 0, 0, 40);
    add_row(2'b11, 0, 0, 2'b11, 9, 8, 2'b00, 0, 0, 40);
    repeat (7) begin
      add_row(2'b11, 0, 0, 2'b00, 0, 0, 2'b00, 0, 0, 40);
    end
    // ma_bp is high by now, so these mallocs are held back.
    add_row(2'b11, 0, 0, 2'b00, 0, 0, 2'b11, 5, 0, 40);
    add_row(2'b11, 0, 0, 2'b00, 0, 0, 2'b11, 7, 6, 40);
    add_row(2'b00, 0, 0, 2'b11, 12, 13, 2'b01, 10, 0, 40);
    // a low threshold lets the head wrap into the returned addresses.
    for (int k = 0; k < 22; k++) begin
      if (k < 4) begin
        fa = k + 1;
      end else if (k < 6) begin
        fa = k + 4;
      end else begin
        fa = k + 5;
      end
      add_row(2'b11, 0, 0, 2'b11, k, 24 + k, (k < 17) ? 2'b01 : 2'b00, fa, 0, 4);
    end
    // refill until the count climbs back above the threshold.
    for (int j = 0; j < 20; j++) begin
      add_row(2'b00, 0, 0, 2'b11, 26 + j, 63 - j, 2'b11, 24 + 2 * j, 25 + 2 * j, 40);
    end
    add_row(2'b00, 0, 0, 2'b00, 0, 0, 2'b00, 0, 0, 40);
    add_row(2'b00, 0, 0, 2'b00, 0, 0, 2'b00, 0, 0, 40);
  endtask

  // a client only mallocs while ready is high and ma_bp is low.
  task automatic drive_row(input row_t r);
    for (int p = 0; p < `BUF_NUMMAPT; p++) begin
      rng = xorshift32(rng);
      ma_din[p] = rng;
    end
    rng = xorshift32(rng);
    ma_write    = (m_ready && !m_bp) ? r.ma_mask : '0;
    wr_req.vld  = r.wr_vld;
    wr_req.adr  = r.wr_adr;
    wr_req.data = rng;
    read        = r.rd_mask;
    rd_adr      = r.rd_adr;
    dq_vld      = r.dq_mask;
    dq_adr      = r.dq_adr;
    bp_thr      = r.thr;
  endtask

  task automatic check_outputs();
    int pop_idx;
    pop_idx = 0;
    assert (ready === m_ready)
      else report_error($sformatf("Fail ready: expected %h, got %h", m_ready, ready));
    assert (ma_bp === m_bp)
      else report_error($sformatf("Fail ma_bp: expected %h, got %h", m_bp, ma_bp));
    for (int p = 0; p < `BUF_NUMRDPT; p++) begin
      assert (rd_rsp[p].vld === exp_vld[p])
        else report_error($sformatf("Fail rd_rsp[%0d].vld: expected %h, got %h",
                                    p, exp_vld[p], rd_rsp[p].vld));
      if (exp_vld[p] && exp_known[p]) begin
        assert (rd_rsp[p].data === exp_data[p])
          else report_error($sformatf("Fail rd_rsp[%0d].data: expected %h, got %h",
                                      p, exp_data[p], rd_rsp[p].data));
      end
    end
    for (int p = 0; p < `BUF_NUMMAPT; p++) begin
      if (ma_write[p]) begin
        assert (pop_idx < free_q.size())
          else report_error("a malloc was issued while the model free list was empty");
        assert (ma_adr[p] === free_q[pop_idx])
          else report_error($sformatf("Fail ma_adr[%0d]: expected %h, got %h",
                                      p, free_q[pop_idx], ma_adr[p]));
        pop_idx++;
      end
    end
  endtask

  // predicts the effect of the coming clock edge.
  task automatic update_model();
    logic      next_bp;
    buf_addr_t a;
    int        npop;
    int        npush;
    next_bp = !m_ready || (m_count <= int'(bp_thr));
    npop    = 0;
    npush   = 0;
    // reads see the word from before this edge.
    for (int p = 0; p < `BUF_NUMRDPT; p++) begin
      if (read[p]) begin
        exp_data[p]  = mem_model[rd_adr[p]];
        exp_known[p] = mem_known[rd_adr[p]];
      end
    end
    exp_vld = read;
    if (!m_ready) begin
      // the sweep puts address i into slot i, one per edge.
      free_q.push_back(buf_addr_t'(m_count));
      m_count++;
      m_ready = (m_count == `BUF_NUMADDR);
    end else begin
      for (int p = 0; p < `BUF_NUMMAPT; p++) begin
        if (ma_write[p]) begin
          a = free_q.pop_front();
          mem_model[a] = ma_din[p];
          mem_known[a] = 1'b1;
          npop++;
        end
      end
      if (wr_req.vld) begin
        mem_model[wr_req.adr] = wr_req.data;
        mem_known[wr_req.adr] = 1'b1;
      end
      for (int p = 0; p < `BUF_NUMDQPT; p++) begin
        if (dq_vld[p]) begin
          assert (!is_free(dq_adr[p]))
            else report_error($sformatf("the table returns address %0d, which is already free",
                                        dq_adr[p]));
          free_q.push_back(dq_adr[p]);
          npush++;
        end
      end
      m_count = m_count + npush - npop;
    end
    m_bp = next_bp;
  endtask

  task automatic run_cycle(input row_t r);
    drive_row(r);
    #2;
    check_outputs();
    update_model();
    @(posedge clk);
    #1;
  endtask

  always @(posedge clk) begin
    cycles++;
    if (cycle_limit > 0 && cycles > cycle_limit) begin
      report_error($sformatf("the run did not finish within %0d cycles", cycle_limit));
    end
  end

  initial begin
    arst_n    = 1'b0;
    ma_write  = '0;
    ma_din    = '0;
    bp_thr    = 8'd40;
    wr_req    = '0;
    read      = '0;
    rd_adr    = '0;
    dq_vld    = '0;
    dq_adr    = '0;
    rng       = SEED;
    errors    = 0;
    cycles    = 0;
    m_count   = 0;
    m_ready   = 1'b0;
    m_bp      = 1'b1;
    exp_vld   = '0;
    exp_known = '0;
    mem_known = '0;
    idle_row     = '0;
    idle_row.thr = 8'd40;
    build_table();
    cycle_limit = rows.size() + `BUF_NUMADDR + 20;

    @(posedge clk);
    #1;
    check_outputs();
    @(posedge clk);
    #1;
    arst_n = 1'b1;

    // the free list fills itself before any row is applied.
    repeat (`BUF_NUMADDR) begin
      run_cycle(idle_row);
    end
    foreach (rows[i]) begin
      run_cycle(rows[i]);
    end
    #2;
    check_outputs();

    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- include/buf_cfg.svh
/*
 * Sizing of the packet buffer and its free-list allocator.
 * Include this wherever the buffer dimensions or port counts are needed.
 * The guard makes repeated inclusion harmless.
 */

`ifndef BUF_CFG_SVH
`define BUF_CFG_SVH

// number of buffer words, each one an allocatable address.
`define BUF_NUMADDR 64

// address width, log2 of BUF_NUMADDR.
`define BUF_BITADDR 6

// width of one buffer word.
`define BUF_WIDTH 32

// malloc ports, each popping one free address per cycle.
`define BUF_NUMMAPT 2

// read ports on the word store.
`define BUF_NUMRDPT 2

// dequeue ports, each returning one address to the free list per cycle.
`define BUF_NUMDQPT 2

`endif

//--- tb.f
+incdir+include
design/buf_pkg.sv
design/free_list.sv
design/data_store.sv
design/buf_mgr_top.sv
dv/buf_mgr_tb.sv
